// ==== source/icache_macros.svh ====
// Instruction cache geometry

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Fetch and refill port widths
`define ICACHE_ADDR_W     32
`define ICACHE_DATA_W     32
`define ICACHE_LINE_W     128

// Cache organisation
`define ICACHE_NB_WAYS    4
`define ICACHE_NB_SETS    16

// Address split
`define ICACHE_SET_W      4     // Set index, addr[7:4]
`define ICACHE_SET_LSB    4
`define ICACHE_TAG_W      7     // Stored tag, addr[14:8]
`define ICACHE_TAG_LSB    8
`define ICACHE_WORD_LSB   2     // Word in line, addr[3:2]

// Replacement LFSR start value
`define ICACHE_LFSR_SEED  8'hA5

`endif

// ==== source/icache_pkg.sv ====
// Instruction cache types

`include "icache_macros.svh"

package icache_pkg;

   typedef enum logic [3:0]
   {
      DISABLED,
      BYPASS_REFILL,
      BYPASS_WAIT_DONE,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      TAG_LOOKUP,
      WAIT_REFILL_GNT,
      WAIT_REFILL_DONE
   } ctrl_state_t;

   typedef logic [`ICACHE_NB_WAYS-1:0] way_mask_t;    // One-hot way
   typedef logic [`ICACHE_SET_W-1:0]   set_idx_t;
   typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
   typedef logic [`ICACHE_LINE_W-1:0]  line_t;

endpackage

// ==== source/icache_tag_store.sv ====
// Tag array with way compare and victim choice

`include "icache_macros.svh"

module icache_tag_store import icache_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  logic      rd_i,
   input  set_idx_t  rd_set_i,
   input  tag_t      lookup_tag_i,

   input  logic      wr_i,
   input  logic      clear_i,
   input  set_idx_t  wr_set_i,
   input  logic      commit_i,

   output logic      hit_o,
   output way_mask_t hit_way_o,
   output way_mask_t victim_way_o
);

   tag_t      tag_mem [`ICACHE_NB_SETS][`ICACHE_NB_WAYS];
   way_mask_t valid_mem [`ICACHE_NB_SETS];

   tag_t      rd_tag_q [`ICACHE_NB_WAYS];
   way_mask_t rd_valid_q;
   way_mask_t victim_q;
   way_mask_t first_free;
   way_mask_t random_way;
   logic [7:0] lfsr_q;

   ////////////////////////////////////////////////////////////////////////////
   // Storage, synchronous read
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rd_i)
      begin
         rd_tag_q   <= tag_mem[rd_set_i];
         rd_valid_q <= valid_mem[rd_set_i];
      end
      if (clear_i)
         valid_mem[wr_set_i] <= '0;      // Drops every way of the set
      else if (wr_i)
      begin
         for (int w = 0; w < `ICACHE_NB_WAYS; w++)
         begin
            if (victim_q[w])
            begin
               tag_mem[wr_set_i][w]   <= lookup_tag_i;
               valid_mem[wr_set_i][w] <= 1'b1;
            end
         end
      end
      if (commit_i)
         victim_q <= (&rd_valid_q) ? random_way : first_free;
   end

   // Compare against the registered lookup tag
   always_comb
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
         hit_way_o[w] = rd_valid_q[w] && (rd_tag_q[w] == lookup_tag_i);
   end

   assign hit_o = |hit_way_o;

   // Lowest invalid way wins
   always_comb
   begin
      first_free = '0;
      for (int w = `ICACHE_NB_WAYS-1; w >= 0; w--)
      begin
         if (!rd_valid_q[w])
            first_free = way_mask_t'(1) << w;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Replacement LFSR, x^8 + x^6 + x^5 + x^4 + 1
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= `ICACHE_LFSR_SEED;
      else if (commit_i)
         lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
   end

   assign random_way   = way_mask_t'(1) << lfsr_q[1:0];
   assign victim_way_o = victim_q;

endmodule

// ==== source/icache_data_store.sv ====
// Line storage and fetch word select

`include "icache_macros.svh"

module icache_data_store import icache_pkg::*;
(
   input  logic                      clk,

   input  logic                      rd_i,
   input  set_idx_t                  rd_set_i,
   input  way_mask_t                 hit_way_i,
   input  logic [1:0]                word_sel_i,

   input  way_mask_t                 wr_way_i,
   input  set_idx_t                  wr_set_i,
   input  line_t                     wr_line_i,
   input  logic                      wr_i,
   input  logic                      from_refill_i,

   output logic [`ICACHE_DATA_W-1:0] rdata_o
);

   line_t line_mem [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];
   line_t rd_line_q [`ICACHE_NB_WAYS];
   line_t sel_line;

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (rd_i)
            rd_line_q[w] <= line_mem[w][rd_set_i];
         if (wr_i && wr_way_i[w])
            line_mem[w][wr_set_i] <= wr_line_i;    // Refill goes to the victim
      end
   end

   // One-hot way mux, refill line passes straight through on a miss
   always_comb
   begin
      sel_line = '0;
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (hit_way_i[w])
            sel_line = sel_line | rd_line_q[w];
      end
      if (from_refill_i)
         sel_line = wr_line_i;
   end

   assign rdata_o = sel_line[word_sel_i*`ICACHE_DATA_W +: `ICACHE_DATA_W];

endmodule

// ==== source/icache_ctrl_fsm.sv ====
// Cache controller FSM

`include "icache_macros.svh"

module icache_ctrl_fsm import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic                      bypass_icache_i,
   input  logic                      flush_icache_i,
   input  logic                      flush_set_req_i,
   input  set_idx_t                  flush_set_addr_i,

   input  logic                      fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
   input  logic                      hit_i,
   input  logic                      refill_gnt_i,
   input  logic                      refill_r_valid_i,

   output logic                      fetch_gnt_o,
   output logic                      fetch_rvalid_o,
   output logic                      rdata_from_refill_o,
   output logic                      tag_rd_o,
   output logic                      tag_wr_o,
   output logic                      tag_clear_o,
   output set_idx_t                  tag_set_o,
   output logic                      victim_commit_o,
   output logic                      refill_req_o,
   output logic [`ICACHE_ADDR_W-1:0] refill_addr_o,
   output logic [`ICACHE_ADDR_W-1:0] lookup_addr_o,
   output logic                      cache_is_bypassed_o,
   output logic                      cache_is_flushed_o,
   output logic                      flush_set_ack_o,
   output logic                      hit_evt_o,
   output logic                      miss_evt_o
);

   ctrl_state_t               state_q, state_d;
   logic [`ICACHE_ADDR_W-1:0] lookup_addr_q;
   set_idx_t                  flush_cnt_q;
   logic                      bypass_pend_q;   // Bypass refill still outstanding
   logic                      ctrl_req;

   assign ctrl_req = bypass_icache_i | flush_icache_i | flush_set_req_i;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= DISABLED;
         flush_cnt_q   <= '0;
         bypass_pend_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= (state_q == FLUSH_ALL) ? flush_cnt_q + 1'b1 : '0;
         if (fetch_gnt_o && cache_is_bypassed_o)
            bypass_pend_q <= 1'b1;
         else if (refill_r_valid_i && cache_is_bypassed_o)
            bypass_pend_q <= 1'b0;
      end
   end

   // Address of the fetch in flight
   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
         lookup_addr_q <= fetch_addr_i;
   end

   assign lookup_addr_o = lookup_addr_q;
   assign refill_addr_o = lookup_addr_q;

   ////////////////////////////////////////////////////////////////////////////
   // Next state and outputs
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d             = state_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      rdata_from_refill_o = 1'b0;
      tag_rd_o            = 1'b0;
      tag_wr_o            = 1'b0;
      tag_clear_o         = 1'b0;
      tag_set_o           = fetch_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W];
      victim_commit_o     = 1'b0;
      refill_req_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;
      hit_evt_o           = 1'b0;
      miss_evt_o          = 1'b0;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_ack_o     = 1'b1;
            if (bypass_icache_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else if (!bypass_pend_q)
               state_d = FLUSH_ALL;           // Enabling always starts clean
         end
         BYPASS_REFILL:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_ack_o     = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = BYPASS_WAIT_DONE;
         end
         BYPASS_WAIT_DONE:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_ack_o     = 1'b1;
            rdata_from_refill_o = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            if (refill_r_valid_i)
               state_d = DISABLED;
         end
         FLUSH_ALL:
         begin
            flush_set_ack_o = 1'b1;
            tag_clear_o     = 1'b1;
            tag_set_o       = flush_cnt_q;
            if (flush_cnt_q == set_idx_t'(`ICACHE_NB_SETS-1))
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = IDLE;
            end
         end
         FLUSH_SET:
         begin
            flush_set_ack_o = 1'b1;
            tag_clear_o     = 1'b1;
            tag_set_o       = flush_set_addr_i;
            state_d         = IDLE;
         end
         IDLE:
         begin
            flush_set_ack_o = 1'b1;
            if (bypass_icache_i)
               state_d = DISABLED;
            else if (flush_icache_i)
               state_d = FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = FLUSH_SET;
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               tag_rd_o    = 1'b1;
               state_d     = TAG_LOOKUP;
            end
         end
         TAG_LOOKUP:
         begin
            if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               hit_evt_o      = 1'b1;
               if (fetch_req_i && !ctrl_req)
               begin
                  fetch_gnt_o = 1'b1;         // Back-to-back hit
                  tag_rd_o    = 1'b1;
               end
               else
                  state_d = IDLE;
            end
            else
            begin
               miss_evt_o      = 1'b1;
               victim_commit_o = 1'b1;
               refill_req_o    = 1'b1;
               state_d         = refill_gnt_i ? WAIT_REFILL_DONE : WAIT_REFILL_GNT;
            end
         end
         WAIT_REFILL_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_REFILL_DONE;
         end
         WAIT_REFILL_DONE:
         begin
            rdata_from_refill_o = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            tag_wr_o            = refill_r_valid_i;
            tag_set_o           = lookup_addr_q[`ICACHE_SET_LSB +: `ICACHE_SET_W];
            if (refill_r_valid_i)
               state_d = IDLE;
         end
         default:
            state_d = DISABLED;
      endcase
   end

endmodule

// ==== source/icache_perf_counters.sv ====
// Fetch performance counters

module icache_perf_counters import icache_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,

   input  logic        clear_i,
   input  logic        enable_i,

   input  logic        trans_evt_i,
   input  logic        hit_evt_i,
   input  logic        miss_evt_i,

   output logic [31:0] trans_count_o,
   output logic [31:0] hit_count_o,
   output logic [31:0] miss_count_o
);

   logic [2:0]  evt;
   logic [31:0] cnt_q [3];

   assign evt = {miss_evt_i, hit_evt_i, trans_evt_i};

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 3; i++)
            cnt_q[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 3; i++)
         begin
            if (clear_i)
               cnt_q[i] <= '0;                 // Clear wins over counting
            else if (enable_i && evt[i])
               cnt_q[i] <= cnt_q[i] + 32'd1;
         end
      end
   end

   assign trans_count_o = cnt_q[0];
   assign hit_count_o   = cnt_q[1];
   assign miss_count_o  = cnt_q[2];

endmodule

// ==== source/pri_icache_top.sv ====
// Private instruction cache top

`include "icache_macros.svh"

module pri_icache_top import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic                      bypass_icache_i,
   input  logic                      flush_icache_i,
   input  logic                      flush_set_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] flush_set_addr_i,
   output logic                      cache_is_bypassed_o,
   output logic                      cache_is_flushed_o,
   output logic                      flush_set_ack_o,

   input  logic                      ctrl_clear_regs_i,
   input  logic                      ctrl_enable_regs_i,

   input  logic                      fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
   output logic                      fetch_gnt_o,
   output logic                      fetch_rvalid_o,
   output logic [`ICACHE_DATA_W-1:0] fetch_rdata_o,

   output logic                      refill_req_o,
   input  logic                      refill_gnt_i,
   output logic [`ICACHE_ADDR_W-1:0] refill_addr_o,
   input  logic                      refill_r_valid_i,
   input  line_t                     refill_r_data_i,

   output logic [31:0]               hit_count_o,
   output logic [31:0]               miss_count_o,
   output logic [31:0]               trans_count_o
);

   logic                      hit, from_refill, tag_rd, tag_wr, tag_clear, commit;
   logic                      hit_evt, miss_evt;
   set_idx_t                  tag_set;
   way_mask_t                 hit_way, victim_way;
   logic [`ICACHE_ADDR_W-1:0] lookup_addr;

   icache_ctrl_fsm u_ctrl (
      .clk, .rst_n,
      .bypass_icache_i, .flush_icache_i, .flush_set_req_i,
      .flush_set_addr_i    (flush_set_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W]),
      .fetch_req_i, .fetch_addr_i,
      .hit_i               (hit),
      .refill_gnt_i, .refill_r_valid_i,
      .fetch_gnt_o, .fetch_rvalid_o,
      .rdata_from_refill_o (from_refill),
      .tag_rd_o            (tag_rd),
      .tag_wr_o            (tag_wr),
      .tag_clear_o         (tag_clear),
      .tag_set_o           (tag_set),
      .victim_commit_o     (commit),
      .refill_req_o, .refill_addr_o,
      .lookup_addr_o       (lookup_addr),
      .cache_is_bypassed_o, .cache_is_flushed_o, .flush_set_ack_o,
      .hit_evt_o           (hit_evt),
      .miss_evt_o          (miss_evt)
   );

   icache_tag_store u_tags (
      .clk, .rst_n,
      .rd_i         (tag_rd),
      .rd_set_i     (tag_set),
      .lookup_tag_i (lookup_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]),
      .wr_i         (tag_wr),
      .clear_i      (tag_clear),
      .wr_set_i     (tag_set),
      .commit_i     (commit),
      .hit_o        (hit),
      .hit_way_o    (hit_way),
      .victim_way_o (victim_way)
   );

   icache_data_store u_data (
      .clk,
      .rd_i          (tag_rd),
      .rd_set_i      (tag_set),
      .hit_way_i     (hit_way),
      .word_sel_i    (lookup_addr[`ICACHE_WORD_LSB +: 2]),
      .wr_way_i      (victim_way),
      .wr_set_i      (tag_set),
      .wr_line_i     (refill_r_data_i),
      .wr_i          (tag_wr),
      .from_refill_i (from_refill),
      .rdata_o       (fetch_rdata_o)
   );

   icache_perf_counters u_perf (
      .clk, .rst_n,
      .clear_i       (ctrl_clear_regs_i),
      .enable_i      (ctrl_enable_regs_i),
      .trans_evt_i   (fetch_gnt_o),       // One transaction per grant
      .hit_evt_i     (hit_evt),
      .miss_evt_i    (miss_evt),
      .trans_count_o, .hit_count_o, .miss_count_o
   );

endmodule

// ==== dv/icache_props.sv ====
// Fetch and refill protocol properties

module icache_props
(
   input logic        clk,
   input logic        rst_n,
   input logic        fetch_req_i,
   input logic        fetch_gnt_i,
   input logic        fetch_rvalid_i,
   input logic        refill_req_i,
   input logic        refill_gnt_i,
   input logic [31:0] refill_addr_i,
   input logic        flushed_i,
   input logic        tag_clear_i      // High in both flush states
);

   int fail_count = 0;

   gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_gnt_i |-> fetch_req_i)
   else
   begin
      fail_count++;
      $error("fetch grant without a fetch request");
   end

   // Request and address held until the refill grant
   refill_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_i && !refill_gnt_i |=> refill_req_i && $stable(refill_addr_i))
   else
   begin
      fail_count++;
      $error("refill request dropped or address changed before the grant");
   end

   no_rvalid_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
      tag_clear_i && !flushed_i |-> !fetch_rvalid_i)
   else
   begin
      fail_count++;
      $error("fetch data returned during a flush");
   end

endmodule

// ==== dv/icache_tb.sv ====
// Instruction cache testbench

`include "icache_macros.svh"

module icache_tb;

   localparam int WAIT_LIMIT  = 200;
   localparam int NB_ENTRIES  = 64;
   localparam int ENTRY_WORDS = 5;      // op, addr, hit, miss, trans

   typedef enum logic [3:0]
   {
      END        = 4'h0,
      FETCH      = 4'h1,
      BYPASS_ON  = 4'h2,
      BYPASS_OFF = 4'h3,
      FLUSH      = 4'h4,
      FLUSH_SET  = 4'h5,
      CLEAR_CNT  = 4'h6,
      CHECK_CNT  = 4'h7
   } pattern_op_t;

   logic                      clk;
   logic                      rst_n;
   logic                      bypass_icache_i;
   logic                      flush_icache_i;
   logic                      flush_set_req_i;
   logic [`ICACHE_ADDR_W-1:0] flush_set_addr_i;
   logic                      cache_is_bypassed_o;
   logic                      cache_is_flushed_o;
   logic                      flush_set_ack_o;
   logic                      ctrl_clear_regs_i;
   logic                      ctrl_enable_regs_i;
   logic                      fetch_req_i;
   logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
   logic                      fetch_gnt_o;
   logic                      fetch_rvalid_o;
   logic [`ICACHE_DATA_W-1:0] fetch_rdata_o;
   logic                      refill_req_o;
   logic                      refill_gnt_i;
   logic [`ICACHE_ADDR_W-1:0] refill_addr_o;
   logic                      refill_r_valid_i;
   logic [`ICACHE_LINE_W-1:0] refill_r_data_i;
   logic [31:0]               hit_count_o;
   logic [31:0]               miss_count_o;
   logic [31:0]               trans_count_o;

   logic [31:0] pat_mem [NB_ENTRIES*ENTRY_WORDS];
   int          errors = 0;
   bit          timed_out = 1'b0;
   int          refill_total = 0;          // Refill requests seen by the memory model
   int          refills_since_clear = 0;
   logic [31:0] last_refill_addr = '0;     // Address of the latest refill request

   pri_icache_top dut (.*);

   bind pri_icache_top icache_props u_props
   (
      .clk,
      .rst_n,
      .fetch_req_i,
      .fetch_gnt_i    (fetch_gnt_o),
      .fetch_rvalid_i (fetch_rvalid_o),
      .refill_req_i   (refill_req_o),
      .refill_gnt_i,
      .refill_addr_i  (refill_addr_o),
      .flushed_i      (cache_is_flushed_o),
      .tag_clear_i    (tag_clear)
   );

   initial
      clk = 1'b0;

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Memory model contents and reporting helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] model_word(input logic [31:0] addr, input logic [1:0] w);
      return {addr[31:4], w, 2'b00} ^ 32'h5A5A_0000;
   endfunction

   function automatic logic [`ICACHE_LINE_W-1:0] model_line(input logic [31:0] addr);
      logic [`ICACHE_LINE_W-1:0] line;
      for (int w = 0; w < 4; w++)
         line[w*32 +: 32] = model_word(addr, w[1:0]);
      return line;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("Failure at %0t: %s", $time, what);
      errors++;
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout at %0t: gave up waiting for %s", $time, what);
      timed_out = 1'b1;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Refill memory, grant after 2 cycles and line 3 cycles after the grant
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : refill_model
      logic [31:0] addr;
      forever
      begin
         @(negedge clk);
         if (refill_req_o)
         begin
            addr = refill_addr_o;
            last_refill_addr = addr;
            refill_total++;
            refills_since_clear++;
            repeat (2) @(posedge clk);
            #1 refill_gnt_i = 1'b1;
            @(posedge clk);
            #1 refill_gnt_i = 1'b0;
            repeat (2) @(posedge clk);
            #1 refill_r_valid_i = 1'b1;
            refill_r_data_i = model_line(addr);
            @(posedge clk);
            #1 refill_r_valid_i = 1'b0;
            refill_r_data_i = '0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Operations
   ////////////////////////////////////////////////////////////////////////////

   // Expect 0 for a refill, 1 for a hit, 2 when either is allowed
   task automatic run_fetch(input logic [31:0] addr, input logic [31:0] expect_hit);
      int          n;
      int          refills_before;
      logic [31:0] exp_word;
      exp_word       = model_word(addr, addr[3:2]);
      refills_before = refill_total;
      fetch_req_i    = 1'b1;
      fetch_addr_i   = addr;
      n = 0;
      @(negedge clk);
      while (!fetch_gnt_o && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (!fetch_gnt_o)
      begin
         note_timeout("fetch_gnt_o");
         return;
      end
      if (bypass_icache_i && !cache_is_bypassed_o)
         report_mismatch("cache_is_bypassed_o", 32'(cache_is_bypassed_o), 1);
      next_cycle();                       // Grant taken on this edge
      fetch_req_i = 1'b0;
      n = 1;
      @(negedge clk);
      while (!fetch_rvalid_o && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (!fetch_rvalid_o)
      begin
         note_timeout("fetch_rvalid_o");
         return;
      end
      if (fetch_rdata_o !== exp_word)
         report_mismatch("fetch_rdata_o", fetch_rdata_o, exp_word);
      if (refill_total != refills_before && !refill_r_valid_i)
         report_failure("fetch data did not come with the refill return");
      if (refill_total != refills_before && last_refill_addr !== addr)
         report_mismatch("refill_addr_o", last_refill_addr, addr);
      if (expect_hit == 1)
      begin
         if (refill_total != refills_before)
            report_failure("refill request issued for a line that should hit");
         if (n != 1)
            report_mismatch("hit latency", n, 1);
      end
      else if (expect_hit == 0 && refill_total != refills_before + 1)
         report_mismatch("refill requests", refill_total - refills_before, 1);
      @(negedge clk);
      if (fetch_rvalid_o)
         report_failure("fetch_rvalid_o pulsed twice for one fetch");
   endtask

   task automatic wait_flush_done(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!(cache_is_flushed_o && !cache_is_bypassed_o) && cycles < WAIT_LIMIT);
      if (!cache_is_flushed_o || cache_is_bypassed_o)
         note_timeout("the end of the full flush");
      else
      begin
         @(negedge clk);
         if (cache_is_flushed_o)
            report_failure("cache_is_flushed_o stayed high after the flush");
      end
   endtask

   task automatic enter_bypass();
      int n;
      bypass_icache_i = 1'b1;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!cache_is_bypassed_o && n < WAIT_LIMIT);
      if (!cache_is_bypassed_o)
         note_timeout("cache_is_bypassed_o");
   endtask

   // An expected count of ff is taken from the refills the model has served
   task automatic check_counters(input logic [31:0] exp_hit, input logic [31:0] exp_miss,
                                 input logic [31:0] exp_trans);
      logic [31:0] hits;
      logic [31:0] misses;
      hits   = exp_hit;
      misses = exp_miss;
      if (misses == 32'hFF)
         misses = refills_since_clear;
      if (hits == 32'hFF)
         hits = exp_trans - refills_since_clear;
      if (hit_count_o !== hits)
         report_mismatch("hit_count_o", hit_count_o, hits);
      if (miss_count_o !== misses)
         report_mismatch("miss_count_o", miss_count_o, misses);
      if (trans_count_o !== exp_trans)
         report_mismatch("trans_count_o", trans_count_o, exp_trans);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : main
      int          cycles;
      int          base;
      int          steps;
      int          errors_before;
      bit          done;
      pattern_op_t op;
      logic [31:0] addr;

      rst_n              = 1'b0;
      bypass_icache_i    = 1'b0;
      flush_icache_i     = 1'b0;
      flush_set_req_i    = 1'b0;
      flush_set_addr_i   = '0;
      ctrl_clear_regs_i  = 1'b0;
      ctrl_enable_regs_i = 1'b1;
      fetch_req_i        = 1'b0;
      fetch_addr_i       = '0;
      refill_gnt_i       = 1'b0;
      refill_r_valid_i   = 1'b0;
      refill_r_data_i    = '0;
      $readmemh("dv/icache_patterns.txt", pat_mem);

      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      @(negedge clk);
      if (fetch_gnt_o || fetch_rvalid_o || refill_req_o)
         report_failure("fetch or refill handshake active right after reset");
      if (!cache_is_bypassed_o)
         report_failure("controller not in DISABLED after reset");
      if (hit_count_o !== 0 || miss_count_o !== 0 || trans_count_o !== 0)
         report_failure("counters not zero after reset");
      wait_flush_done(cycles);            // Enabling the cache flushes it first

      done  = 1'b0;
      steps = 0;
      for (int idx = 0; idx < NB_ENTRIES && !done && !timed_out; idx++)
      begin
         base = idx * ENTRY_WORDS;
         if ($isunknown(pat_mem[base]))
         begin
            report_failure("pattern list missing or ended without an END entry");
            done = 1'b1;
         end
         else
         begin
            op            = pattern_op_t'(pat_mem[base][3:0]);
            addr          = pat_mem[base+1];
            errors_before = errors;
            steps++;
            next_cycle();
            case (op)
               FETCH:
                  run_fetch(addr, pat_mem[base+2]);
               BYPASS_ON:
                  enter_bypass();
               BYPASS_OFF:
               begin
                  bypass_icache_i = 1'b0;
                  wait_flush_done(cycles);
               end
               FLUSH:
               begin
                  flush_icache_i = 1'b1;
                  next_cycle();
                  flush_icache_i = 1'b0;
                  wait_flush_done(cycles);
                  if (!timed_out && cycles != 16)
                     report_mismatch("full flush cycles", cycles, 16);
               end
               FLUSH_SET:
               begin
                  flush_set_addr_i = addr;
                  flush_set_req_i  = 1'b1;
                  next_cycle();
                  flush_set_req_i = 1'b0;
                  @(negedge clk);
                  if (!flush_set_ack_o)
                     report_mismatch("flush_set_ack_o", 32'(flush_set_ack_o), 1);
               end
               CLEAR_CNT:
               begin
                  ctrl_clear_regs_i = 1'b1;
                  next_cycle();
                  ctrl_clear_regs_i   = 1'b0;
                  ctrl_enable_regs_i  = addr[0];
                  refills_since_clear = 0;
               end
               CHECK_CNT:
                  check_counters(pat_mem[base+2], pat_mem[base+3], pat_mem[base+4]);
               END:
                  done = 1'b1;
               default:
                  report_failure("unknown opcode in the pattern list");
            endcase
            $display("Step %0d %s %h: %s", idx, op.name(), addr,
                     (errors == errors_before && !timed_out) ? "ok" : "failed");
         end
      end
      if (!done && !timed_out)
         report_failure("pattern list has no END entry");

      $display("%0d steps, %0d errors, %0d assertion failures, timeout %0d",
               steps, errors, dut.u_props.fail_count, timed_out);
      if (errors == 0 && !timed_out && dut.u_props.fail_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== dv/icache_patterns.txt ====
// op addr hit miss trans. op 1 fetch 2 bypass-on 3 bypass-off 4 flush 5 set-flush 6 clear 7 check 0 end
// fetch hit 0 refill 1 hit 2 either. clear addr bit 0 sets count enable. check ff uses model refills
6 00000001 0 0 0
1 00001004 0 0 0
1 00001008 1 0 0
7 00000000 1 1 2
6 00000001 0 0 0
1 00002030 0 0 0
1 00002130 0 0 0
1 00002230 0 0 0
1 00002330 0 0 0
1 00002430 0 0 0
1 0000203c 2 0 0
1 00002134 2 0 0
1 00002238 2 0 0
1 0000233c 2 0 0
1 00002430 2 0 0
7 00000000 ff ff a
1 00001000 1 0 0
4 00000000 0 0 0
1 0000100c 0 0 0
1 00003050 0 0 0
1 00003054 1 0 0
5 00003050 0 0 0
1 00003058 0 0 0
1 00001000 1 0 0
2 00000000 0 0 0
1 00001004 0 0 0
1 00001004 0 0 0
3 00000000 0 0 0
1 00001008 0 0 0
6 00000000 0 0 0
1 00001008 1 0 0
7 00000000 0 0 0
6 00000001 0 0 0
1 0000100c 1 0 0
7 00000000 1 0 1
0 00000000 0 0 0

// ==== compile.f ====
+incdir+source
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_ctrl_fsm.sv
source/icache_perf_counters.sv
source/pri_icache_top.sv
dv/icache_props.sv
dv/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
